/* Makefile */
# Verilator build and run of the decode stage testbench

LOG = sim.log

all: run

compile:
	verilator --binary --timing --assert -f sim.f --top-module ThorDecodeTb -Mdir obj_dir

run: compile
	./obj_dir/VThorDecodeTb | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "Result: PASSED" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all compile run clean

/* rtl/ThorDecodeCsr.sv */
module ThorDecodeCsr
(
	input logic clk,
	input logic reset,
	input logic awvalid,
	output logic awready,
	input logic [ThorDecodePkg::CsrAddrWidth-1:0] awaddr,
	input logic wvalid,
	output logic wready,
	input logic [31:0] wdata,
	input logic [3:0] wstrb,
	output logic bvalid,
	input logic bready,
	output logic [1:0] bresp,
	input logic arvalid,
	output logic arready,
	input logic [ThorDecodePkg::CsrAddrWidth-1:0] araddr,
	output logic rvalid,
	input logic rready,
	output logic [31:0] rdata,
	output logic [1:0] rresp,
	ThorDecodeCtrlIf.csr ctrl
);
	import ThorDecodePkg::*;

	logic enableQ;
	logic [31:0] issuedCount;
	logic [31:0] stallCount;
	logic [31:0] readMux;
	logic writeGo;
	logic readGo;

	function automatic logic isMapped(input logic [CsrAddrWidth-1:0] addr);
		return (addr == CsrCtrl) || (addr == CsrIssued) || (addr == CsrStalls)
			|| (addr == CsrPendLo) || (addr == CsrPendHi);
	endfunction

	assign writeGo = awvalid && awready && wvalid && wready;
	assign readGo = arvalid && arready;

	// ======================================================================
	// Write channel
	// ======================================================================

	// AW and W are taken together in one cycle, and never while B is still owed
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			awready <= 1'b0;
			wready <= 1'b0;
			bvalid <= 1'b0;
		end
		else
		begin
			awready <= awvalid && wvalid && !awready && !bvalid;
			wready <= awvalid && wvalid && !awready && !bvalid;
			if (writeGo)
				bvalid <= 1'b1;
			else if (bvalid && bready)
				bvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (writeGo)
			bresp <= isMapped(awaddr) ? RespOkay : RespSlvErr;
	end

	// Control bit and counters, a write to a counter clears it
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			enableQ <= 1'b0;
			issuedCount <= '0;
			stallCount <= '0;
		end
		else
		begin
			if (writeGo && (awaddr == CsrCtrl) && wstrb[0])
				enableQ <= wdata[0];
			if (writeGo && (awaddr == CsrIssued))
				issuedCount <= '0;
			else if (ctrl.issued)
				issuedCount <= issuedCount + 32'd1;
			if (writeGo && (awaddr == CsrStalls))
				stallCount <= '0;
			else if (ctrl.stalled)
				stallCount <= stallCount + 32'd1;
		end
	end

	assign ctrl.enable = enableQ;

	// ======================================================================
	// Read channel
	// ======================================================================

	always_comb
	begin
		case (araddr)
			CsrCtrl: readMux = {31'd0, enableQ};
			CsrIssued: readMux = issuedCount;
			CsrStalls: readMux = stallCount;
			CsrPendLo: readMux = ctrl.pending[31:0];
			CsrPendHi: readMux = ctrl.pending[63:32];
			default: readMux = '0;
		endcase
	end

	// One read in flight at a time
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			arready <= 1'b0;
			rvalid <= 1'b0;
		end
		else
		begin
			arready <= arvalid && !arready && !rvalid;
			if (readGo)
				rvalid <= 1'b1;
			else if (rvalid && rready)
				rvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (readGo)
		begin
			rdata <= readMux;
			rresp <= isMapped(araddr) ? RespOkay : RespSlvErr;
		end
	end

	// Every write response traces back to a completed AW/W handshake
	assert property (@(posedge clk) disable iff (reset)
		$rose(bvalid) |-> $past(awvalid && awready && wvalid && wready))
		else $error("bvalid raised without an accepted write");

endmodule

/* rtl/ThorDecodeCtrlIf.sv */
interface ThorDecodeCtrlIf;
	import ThorDecodePkg::*;

	// Issue enable from the register block
	logic enable;
	// Single-cycle event pulses from the stage
	logic issued;
	logic stalled;
	// One bit per register with a write still in flight
	logic [NumRegs-1:0] pending;

	// Register block owns enable and watches everything else
	modport csr (output enable, input issued, input stalled, input pending);

	// Stage obeys enable and reports its events
	modport stage (input enable, output issued, output stalled);

	// Scoreboard publishes the pending mask
	modport board (output pending);

endinterface

/* rtl/ThorDecodePkg.sv */
package ThorDecodePkg;

	// ======================================================================
	// Register file and register block constants
	// ======================================================================

	localparam int NumRegs = 64;
	// Link registers for BSR/JSR start here, instruction bits 8:7 pick one of four
	localparam int LinkRegBase = 56;
	localparam int ReturnReg = 62;
	localparam int CsrAddrWidth = 5;

	// Byte offsets of the register block
	localparam logic [CsrAddrWidth-1:0] CsrCtrl = 5'h00;
	localparam logic [CsrAddrWidth-1:0] CsrIssued = 5'h04;
	localparam logic [CsrAddrWidth-1:0] CsrStalls = 5'h08;
	localparam logic [CsrAddrWidth-1:0] CsrPendLo = 5'h0C;
	localparam logic [CsrAddrWidth-1:0] CsrPendHi = 5'h10;

	// AXI4-Lite response codes
	localparam logic [1:0] RespOkay = 2'b00;
	localparam logic [1:0] RespSlvErr = 2'b10;

	// ======================================================================
	// Instruction encodings
	// ======================================================================

	// Register 0 doubles as "no register"
	typedef logic [$clog2(NumRegs)-1:0] regspec_t;

	typedef enum logic [6:0] {
		OP_R2 = 7'd2, OP_FLT2 = 7'd12, OP_FLT3 = 7'd13,
		OP_BSR = 7'd32, OP_JSR = 7'd33, OP_RTD = 7'd34,
		OP_ADDI = 7'd4, OP_SUBFI = 7'd5, OP_CMPI = 7'd6, OP_MULI = 7'd7,
		OP_DIVI = 7'd8, OP_SLTI = 7'd9, OP_MULUI = 7'd14, OP_DIVUI = 7'd15,
		OP_ANDI = 7'd16, OP_ORI = 7'd17, OP_EORI = 7'd18,
		OP_CSR = 7'd24, OP_MOV = 7'd25,
		OP_LDB = 7'd64, OP_LDBU = 7'd65, OP_LDW = 7'd66, OP_LDWU = 7'd67,
		OP_LDT = 7'd68, OP_LDTU = 7'd69, OP_LDO = 7'd70, OP_LDA = 7'd74,
		OP_LDX = 7'd79,
		OP_STB = 7'd80, OP_STO = 7'd83,
		OP_BEQ = 7'd38,
		OP_NOP = 7'd127
	} opcode_t;

	// Function codes of the register-register group, any other value is undefined
	typedef enum logic [6:0] {
		FN_ADD = 7'h04, FN_CMP = 7'h05, FN_MUL = 7'h06, FN_DIV = 7'h07,
		FN_SUB = 7'h08, FN_MULU = 7'h0E, FN_DIVU = 7'h0F, FN_MULH = 7'h10,
		FN_MOD = 7'h11, FN_MULUH = 7'h12, FN_MODU = 7'h13,
		FN_AND = 7'h20, FN_OR = 7'h21, FN_EOR = 7'h22, FN_ANDC = 7'h23,
		FN_NAND = 7'h24, FN_NOR = 7'h25, FN_ENOR = 7'h26, FN_ORC = 7'h27,
		FN_SEQ = 7'h28, FN_SNE = 7'h29, FN_SLT = 7'h2A, FN_SLE = 7'h2B,
		FN_SLTU = 7'h2C, FN_SLEU = 7'h2D
	} func_t;

	// 40-bit instruction, the field positions are shared by all formats
	typedef struct packed {
		// Bits 39:33, only meaningful for OP_R2
		func_t func;
		// Bits 32:25 hold immediates and are not decoded here
		logic [7:0] spare;
		regspec_t rb;
		regspec_t ra;
		regspec_t rt;
		opcode_t opcode;
	} instruction_t;

	// Result of decode as it leaves the stage
	typedef struct packed {
		regspec_t rt;
		regspec_t ra;
		regspec_t rb;
		logic writesRt;
		logic usesRa;
		logic usesRb;
	} decodedOp_t;

endpackage

/* rtl/ThorDecodeRt.sv */
module ThorDecodeRt
(
	input ThorDecodePkg::instruction_t instr,
	output ThorDecodePkg::regspec_t rt
);
	import ThorDecodePkg::*;

	// Target register selection, register 0 means nothing is written
	always_comb
	begin
		case (instr.opcode)
			OP_R2:
			begin
				// Only defined functions write a result
				case (instr.func)
					FN_ADD, FN_CMP, FN_MUL, FN_DIV, FN_SUB,
					FN_MULU, FN_DIVU, FN_MULH, FN_MOD, FN_MULUH, FN_MODU,
					FN_AND, FN_OR, FN_EOR, FN_ANDC, FN_NAND, FN_NOR,
					FN_ENOR, FN_ORC,
					FN_SEQ, FN_SNE, FN_SLT, FN_SLE, FN_SLTU, FN_SLEU:
						rt = instr.rt;
					default:
						rt = '0;
				endcase
			end
			OP_FLT2, OP_FLT3:
				rt = instr.rt;
			// Subroutine calls write one of four link registers
			// The link index sits in the low two bits of the Rt field
			OP_BSR, OP_JSR:
				rt = regspec_t'(LinkRegBase + int'(instr[8:7]));
			// Return-and-deallocate updates the stack pointer
			OP_RTD:
				rt = regspec_t'(ReturnReg);
			// Immediate ALU group
			OP_ADDI, OP_SUBFI, OP_CMPI, OP_MULI, OP_DIVI, OP_SLTI,
			OP_MULUI, OP_DIVUI, OP_ANDI, OP_ORI, OP_EORI:
				rt = instr.rt;
			OP_CSR, OP_MOV:
				rt = instr.rt;
			// Every load width writes its destination
			OP_LDB, OP_LDBU, OP_LDW, OP_LDWU, OP_LDT, OP_LDTU,
			OP_LDO, OP_LDA, OP_LDX:
				rt = instr.rt;
			// Stores, branches and NOP write nothing
			default:
				rt = '0;
		endcase
	end

endmodule

/* rtl/ThorDecodeSrc.sv */
module ThorDecodeSrc
(
	input ThorDecodePkg::instruction_t instr,
	output ThorDecodePkg::regspec_t ra,
	output ThorDecodePkg::regspec_t rb,
	output logic usesRa,
	output logic usesRb
);
	import ThorDecodePkg::*;

	// Which source operands the opcode reads
	always_comb
	begin
		usesRa = 1'b0;
		usesRb = 1'b0;
		case (instr.opcode)
			// Two-operand groups, stores read the address base and the data
			OP_R2, OP_FLT3, OP_STB, OP_STO:
			begin
				usesRa = 1'b1;
				usesRb = 1'b1;
			end
			OP_ADDI, OP_SUBFI, OP_CMPI, OP_MULI, OP_DIVI, OP_SLTI,
			OP_MULUI, OP_DIVUI, OP_ANDI, OP_ORI, OP_EORI:
				usesRa = 1'b1;
			// Loads only need the base register
			OP_LDB, OP_LDBU, OP_LDW, OP_LDWU, OP_LDT, OP_LDTU,
			OP_LDO, OP_LDA, OP_LDX:
				usesRa = 1'b1;
			OP_MOV, OP_FLT2, OP_BEQ, OP_CSR:
				usesRa = 1'b1;
			// BSR, JSR, RTD and NOP read no general register
			default:
			begin
				usesRa = 1'b0;
				usesRb = 1'b0;
			end
		endcase
	end

	// An unused source is reported as register 0 so it never hits the scoreboard
	assign ra = usesRa ? instr.ra : '0;
	assign rb = usesRb ? instr.rb : '0;

endmodule

/* rtl/ThorDecodeStage.sv */
module ThorDecodeStage
(
	input logic clk,
	input logic reset,
	input logic inValid,
	input ThorDecodePkg::instruction_t inInstr,
	output logic inReady,
	output logic outValid,
	output ThorDecodePkg::decodedOp_t outOp,
	input logic outReady,
	input logic hazard,
	output logic setValid,
	output ThorDecodePkg::regspec_t setReg,
	output ThorDecodePkg::decodedOp_t checkOp,
	ThorDecodeCtrlIf.stage ctrl
);
	import ThorDecodePkg::*;

	regspec_t rtDec;
	regspec_t raDec;
	regspec_t rbDec;
	logic usesRaDec;
	logic usesRbDec;
	logic accept;

	ThorDecodeRt rtDecoder (.instr(inInstr), .rt(rtDec));

	ThorDecodeSrc srcDecoder (
		.instr(inInstr),
		.ra(raDec),
		.rb(rbDec),
		.usesRa(usesRaDec),
		.usesRb(usesRbDec)
	);

	// Candidate op, also handed to the scoreboard for the hazard check
	assign checkOp = '{rt: rtDec, ra: raDec, rb: rbDec, writesRt: (rtDec != '0),
		usesRa: usesRaDec, usesRb: usesRbDec};

	// Room in the output register, issue enabled and no register conflict
	assign inReady = ctrl.enable && (!outValid || outReady) && !hazard;
	assign accept = inValid && inReady;

	// Issue marks the target pending at the same edge
	assign setValid = accept && checkOp.writesRt;
	assign setReg = checkOp.rt;

	assign ctrl.issued = accept;
	// Counts waiting cycles caused by conflicts, not back-pressure
	assign ctrl.stalled = inValid && ctrl.enable && hazard;

	// Output register valid flag
	always_ff @(posedge clk)
	begin
		if (reset)
			outValid <= 1'b0;
		else if (accept)
			outValid <= 1'b1;
		else if (outReady)
			outValid <= 1'b0;
	end

	// Payload only moves on acceptance
	always_ff @(posedge clk)
	begin
		if (accept)
			outOp <= checkOp;
	end

	// A stalled output holds both its valid and its data
	assert property (@(posedge clk) disable iff (reset)
		(outValid && !outReady) |=> (outValid && $stable(outOp)))
		else $error("Output changed under back-pressure");

endmodule

/* rtl/ThorDecodeTop.sv */
module ThorDecodeTop
(
	input logic clk,
	input logic reset,
	// Instruction stream in
	input logic inValid,
	input ThorDecodePkg::instruction_t inInstr,
	output logic inReady,
	// Decoded ops out
	output logic outValid,
	output ThorDecodePkg::decodedOp_t outOp,
	input logic outReady,
	// Writeback report from execution
	input logic wbValid,
	input ThorDecodePkg::regspec_t wbReg,
	// AXI4-Lite slave
	input logic awvalid,
	output logic awready,
	input logic [ThorDecodePkg::CsrAddrWidth-1:0] awaddr,
	input logic wvalid,
	output logic wready,
	input logic [31:0] wdata,
	input logic [3:0] wstrb,
	output logic bvalid,
	input logic bready,
	output logic [1:0] bresp,
	input logic arvalid,
	output logic arready,
	input logic [ThorDecodePkg::CsrAddrWidth-1:0] araddr,
	output logic rvalid,
	input logic rready,
	output logic [31:0] rdata,
	output logic [1:0] rresp
);
	import ThorDecodePkg::*;

	logic hazard;
	logic setValid;
	regspec_t setReg;
	decodedOp_t checkOp;

	ThorDecodeCtrlIf ctrlIf ();

	ThorDecodeStage stage (
		.clk, .reset, .inValid, .inInstr, .inReady, .outValid, .outOp, .outReady,
		.hazard, .setValid, .setReg, .checkOp, .ctrl(ctrlIf.stage)
	);

	ThorScoreboard board (
		.clk, .reset, .setValid, .setReg, .wbValid, .wbReg, .checkOp, .hazard,
		.ctrl(ctrlIf.board)
	);

	ThorDecodeCsr csr (
		.clk, .reset, .awvalid, .awready, .awaddr, .wvalid, .wready, .wdata, .wstrb,
		.bvalid, .bready, .bresp, .arvalid, .arready, .araddr, .rvalid, .rready,
		.rdata, .rresp, .ctrl(ctrlIf.csr)
	);

endmodule

/* rtl/ThorScoreboard.sv */
module ThorScoreboard
(
	input logic clk,
	input logic reset,
	input logic setValid,
	input ThorDecodePkg::regspec_t setReg,
	input logic wbValid,
	input ThorDecodePkg::regspec_t wbReg,
	input ThorDecodePkg::decodedOp_t checkOp,
	output logic hazard,
	ThorDecodeCtrlIf.board ctrl
);
	import ThorDecodePkg::*;

	logic [NumRegs-1:0] pendingQ;

	// ======================================================================
	// Pending bits
	// ======================================================================

	// Writeback clears first, so a set at the same edge wins
	// The hazard check keeps the two from naming the same register
	always_ff @(posedge clk)
	begin
		if (reset)
			pendingQ <= '0;
		else
		begin
			if (wbValid)
				pendingQ[wbReg] <= 1'b0;
			// The stage only raises setValid for a nonzero target
			if (setValid)
				pendingQ[setReg] <= 1'b1;
		end
	end

	assign ctrl.pending = pendingQ;

	// Any operand or the target still in flight blocks the candidate
	// There is no bypass, so a writeback only helps from the next cycle
	assign hazard = (checkOp.usesRa && pendingQ[checkOp.ra])
		|| (checkOp.usesRb && pendingQ[checkOp.rb])
		|| (checkOp.writesRt && pendingQ[checkOp.rt]);

	// ======================================================================
	// Checks
	// ======================================================================

	// The execution side may only retire writes that were issued
	assert property (@(posedge clk) disable iff (reset)
		wbValid |-> pendingQ[wbReg])
		else $error("Writeback to register %0d with no pending write", wbReg);

	// Register 0 is a sink and must never be marked as a target by the stage
	assert property (@(posedge clk) disable iff (reset) !pendingQ[0])
		else $error("Register 0 marked pending");

endmodule

/* sim.f */
rtl/ThorDecodePkg.sv
rtl/ThorDecodeCtrlIf.sv
rtl/ThorDecodeRt.sv
rtl/ThorDecodeSrc.sv
rtl/ThorScoreboard.sv
rtl/ThorDecodeStage.sv
rtl/ThorDecodeCsr.sv
rtl/ThorDecodeTop.sv
verif/ThorClockGen.sv
verif/ThorDecodeTb.sv

/* verif/ThorClockGen.sv */
module ThorClockGen
(
	output logic clk
);

	// Free-running clock, 4 units low and 4 units high
	initial
	begin
		clk = 1'b0;
		forever
			#4 clk = ~clk;
	end

endmodule

/* verif/ThorDecodeTb.sv */
module ThorDecodeTb;
	import ThorDecodePkg::*;

	// The tests take about 1000 cycles, so the limit leaves a wide margin
	localparam int CycleLimit = 4000;

	logic clk;
	logic reset;
	logic inValid;
	instruction_t inInstr;
	logic inReady;
	logic outValid;
	decodedOp_t outOp;
	logic outReady;
	logic wbValid;
	regspec_t wbReg;
	logic awvalid, awready, wvalid, wready, bvalid, bready;
	logic arvalid, arready, rvalid, rready;
	logic [CsrAddrWidth-1:0] awaddr, araddr;
	logic [31:0] wdata, rdata;
	logic [3:0] wstrb;
	logic [1:0] bresp, rresp;

	// Ops expected at the output, oldest first
	decodedOp_t expQ[$];
	string curTest = "reset";
	int outCount = 0;
	int acceptCount = 0;
	int cycleCount = 0;
	logic [31:0] lfsrState = 32'h454280a4;

	ThorClockGen clockGen (.clk(clk));

	ThorDecodeTop dut_i (.*);

	// ======================================================================
	// Checking
	// ======================================================================

	task automatic failNow(input string why);
		$display("%s", why);
		$display("Result: FAILED");
		$fatal(1, "Stopping at the first error");
	endtask

	task automatic compareOp(input string testName, input decodedOp_t expected,
		input decodedOp_t actual);
		if (actual !== expected)
			failNow($sformatf("Mismatch in %s: expected op %h, actual op %h",
				testName, expected, actual));
	endtask

	task automatic compareWord(input string testName, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
			failNow($sformatf("Mismatch in %s: expected %h, actual %h",
				testName, expected, actual));
	endtask

	task automatic compareResp(input string testName, input logic [1:0] expected,
		input logic [1:0] actual);
		if (actual !== expected)
			failNow($sformatf("Mismatch in %s: expected resp %b, actual resp %b",
				testName, expected, actual));
	endtask

	// ======================================================================
	// Reference model and stimulus helpers
	// ======================================================================

	// Walks the function enum, so only the defined codes count as listed
	function automatic logic isListedFunc(input logic [6:0] code);
		func_t fn;
		logic found;
		fn = fn.first();
		found = 1'b0;
		repeat (fn.num())
		begin
			if (fn == code)
				found = 1'b1;
			fn = fn.next();
		end
		return found;
	endfunction

	function automatic decodedOp_t modelDecode(input instruction_t instr);
		decodedOp_t op;
		logic immAlu;
		logic load;
		immAlu = (instr.opcode inside {OP_ADDI, OP_SUBFI, OP_CMPI, OP_MULI, OP_DIVI,
			OP_SLTI, OP_MULUI, OP_DIVUI, OP_ANDI, OP_ORI, OP_EORI});
		load = (instr.opcode inside {OP_LDB, OP_LDBU, OP_LDW, OP_LDWU, OP_LDT, OP_LDTU,
			OP_LDO, OP_LDA, OP_LDX});
		op = '0;
		if (((instr.opcode == OP_R2) && isListedFunc(instr.func)) || immAlu || load
			|| (instr.opcode inside {OP_FLT2, OP_FLT3, OP_CSR, OP_MOV}))
			op.rt = instr.rt;
		else if (instr.opcode inside {OP_BSR, OP_JSR})
			op.rt = regspec_t'(LinkRegBase + instr.rt[1:0]);
		else if (instr.opcode == OP_RTD)
			op.rt = regspec_t'(ReturnReg);
		op.usesRb = (instr.opcode inside {OP_R2, OP_FLT3, OP_STB, OP_STO});
		op.usesRa = op.usesRb || immAlu || load
			|| (instr.opcode inside {OP_MOV, OP_FLT2, OP_BEQ, OP_CSR});
		op.ra = op.usesRa ? instr.ra : '0;
		op.rb = op.usesRb ? instr.rb : '0;
		op.writesRt = (op.rt != '0);
		return op;
	endfunction

	function automatic instruction_t makeInstr(input opcode_t opc, input logic [6:0] fn,
		input regspec_t rt, input regspec_t ra, input regspec_t rb);
		instruction_t instr;
		instr = '0;
		instr.opcode = opc;
		instr.func = func_t'(fn);
		instr.rt = rt;
		instr.ra = ra;
		instr.rb = rb;
		return instr;
	endfunction

	// Spreads register numbers over 1 to 53 so neighbouring tests differ
	function automatic regspec_t pickReg(input int n, input int slot);
		return regspec_t'(1 + (3 * n + slot) % 53);
	endfunction

	// Fibonacci LFSR with taps 32, 22, 2 and 1
	function automatic logic lfsrBit();
		logic fb;
		fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
		lfsrState = {lfsrState[30:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] lfsrBits(input int n);
		logic [31:0] v;
		v = '0;
		repeat (n)
			v = {v[30:0], lfsrBit()};
		return v;
	endfunction

	// ======================================================================
	// Bus drivers, all entered and left on a falling edge
	// ======================================================================

	task automatic axiRead(input logic [CsrAddrWidth-1:0] addr, output logic [31:0] data,
		output logic [1:0] resp);
		araddr = addr;
		arvalid = 1'b1;
		rready = 1'b1;
		@(negedge clk);
		while (!arready)
			@(negedge clk);
		// AR completes at the coming rising edge
		@(negedge clk);
		arvalid = 1'b0;
		while (!rvalid)
			@(negedge clk);
		data = rdata;
		resp = rresp;
		@(negedge clk);
		rready = 1'b0;
	endtask

	task automatic checkRead(input logic [CsrAddrWidth-1:0] addr, input logic [31:0] expData,
		input logic [1:0] expResp);
		logic [31:0] data;
		logic [1:0] resp;
		axiRead(addr, data, resp);
		compareResp(curTest, expResp, resp);
		compareWord(curTest, expData, data);
	endtask

	task automatic checkWrite(input logic [CsrAddrWidth-1:0] addr, input logic [31:0] data,
		input logic [1:0] expResp);
		awaddr = addr;
		wdata = data;
		wstrb = 4'hF;
		awvalid = 1'b1;
		wvalid = 1'b1;
		bready = 1'b1;
		@(negedge clk);
		while (!awready)
			@(negedge clk);
		@(negedge clk);
		awvalid = 1'b0;
		wvalid = 1'b0;
		while (!bvalid)
			@(negedge clk);
		compareResp(curTest, expResp, bresp);
		@(negedge clk);
		bready = 1'b0;
	endtask

	// inReady is combinational, so it is sampled a little after the inputs move
	task automatic sendInstr(input instruction_t instr);
		inInstr = instr;
		inValid = 1'b1;
		#1;
		while (!inReady)
		begin
			@(negedge clk);
			#1;
		end
		expQ.push_back(modelDecode(instr));
		acceptCount++;
		@(negedge clk);
		inValid = 1'b0;
	endtask

	task automatic writeback(input regspec_t r);
		wbReg = r;
		wbValid = 1'b1;
		@(negedge clk);
		wbValid = 1'b0;
	endtask

	task automatic waitOutputs(input int count);
		while (outCount < count)
			@(negedge clk);
	endtask

	// Issue one op, wait for it, then retire its target
	task automatic issueAndRetire(input instruction_t instr);
		decodedOp_t exp;
		int target;
		exp = modelDecode(instr);
		target = outCount + 1;
		sendInstr(instr);
		waitOutputs(target);
		if (exp.writesRt)
			writeback(exp.rt);
	endtask

	// Output monitor, samples midway between the falling and rising edge
	always @(negedge clk)
	begin
		#2;
		if (!reset && outValid && outReady)
		begin
			if (expQ.size() == 0)
				failNow($sformatf("Unexpected decoded op %h in %s", outOp, curTest));
			else
				compareOp(curTest, expQ.pop_front(), outOp);
			outCount++;
		end
	end

	always @(posedge clk)
	begin
		cycleCount++;
		if (cycleCount >= CycleLimit)
			failNow($sformatf("Timeout after %0d cycles in %s", cycleCount, curTest));
	end

	// ======================================================================
	// Tests
	// ======================================================================

	task automatic testReset();
		curTest = "reset";
		compareWord(curTest, 32'd0, {31'd0, outValid});
		compareWord(curTest, 32'd0, {31'd0, inReady});
		checkRead(CsrCtrl, 32'd0, RespOkay);
		checkRead(CsrIssued, 32'd0, RespOkay);
		checkRead(CsrPendLo, 32'd0, RespOkay);
		checkRead(CsrPendHi, 32'd0, RespOkay);
	endtask

	task automatic testDecode();
		opcode_t opc;
		func_t fn;
		int n;
		int k;
		curTest = "decode";
		n = 0;
		checkWrite(CsrCtrl, 32'd1, RespOkay);
		opc = opc.first();
		repeat (opc.num())
		begin
			issueAndRetire(makeInstr(opc, FN_ADD, pickReg(n, 0), pickReg(n, 1), pickReg(n, 2)));
			n++;
			opc = opc.next();
		end
		// Low two bits of the Rt field pick link registers 56 to 59
		for (k = 0; k < 4; k++)
		begin
			issueAndRetire(makeInstr(OP_BSR, FN_ADD, regspec_t'(8 + k), 6'd1, 6'd2));
			issueAndRetire(makeInstr(OP_JSR, FN_ADD, regspec_t'(12 + k), 6'd3, 6'd4));
		end
		fn = fn.first();
		repeat (fn.num())
		begin
			issueAndRetire(makeInstr(OP_R2, fn, pickReg(n, 0), pickReg(n, 1), pickReg(n, 2)));
			n++;
			fn = fn.next();
		end
		issueAndRetire(makeInstr(OP_R2, 7'h7F, pickReg(n, 0), pickReg(n, 1), pickReg(n, 2)));
	endtask

	task automatic testHazard();
		logic [31:0] data;
		logic [1:0] resp;
		int base;
		int i;
		curTest = "hazard";
		base = outCount;
		sendInstr(makeInstr(OP_LDO, FN_ADD, 6'd9, 6'd1, 6'd0));
		waitOutputs(base + 1);
		// The add reads r9 and has to wait for its writeback
		fork
			sendInstr(makeInstr(OP_R2, FN_ADD, 6'd10, 6'd9, 6'd3));
		join_none
		for (i = 0; i < 3; i++)
		begin
			checkRead(CsrPendLo, 32'h0000_0200, RespOkay);
			if (outCount != base + 1)
				failNow("Add was issued while register 9 was still pending");
		end
		writeback(6'd9);
		waitOutputs(base + 2);
		axiRead(CsrStalls, data, resp);
		compareResp(curTest, RespOkay, resp);
		if (data == 32'd0)
			failNow("Stall counter stayed at zero across a hazard");
		checkRead(CsrPendLo, 32'h0000_0400, RespOkay);
		writeback(6'd10);
		checkRead(CsrPendLo, 32'd0, RespOkay);
	endtask

	task automatic testBackPressure();
		instruction_t firstInstr;
		decodedOp_t held;
		int base;
		int seen;
		curTest = "backpressure";
		base = outCount;
		outReady = 1'b0;
		firstInstr = makeInstr(OP_ADDI, FN_ADD, 6'd20, 6'd21, 6'd0);
		sendInstr(firstInstr);
		fork
			sendInstr(makeInstr(OP_R2, FN_SUB, 6'd23, 6'd24, 6'd25));
		join_none
		@(negedge clk);
		// The stalled output has to keep showing the first op
		held = modelDecode(firstInstr);
		seen = acceptCount;
		repeat (5)
		begin
			@(negedge clk);
			compareWord(curTest, 32'd1, {31'd0, outValid});
			compareOp(curTest, held, outOp);
			if (acceptCount != seen)
				failNow("Second instruction was accepted while the output was stalled");
		end
		outReady = 1'b1;
		waitOutputs(base + 2);
		writeback(6'd20);
		writeback(6'd23);
	endtask

	task automatic testRandom();
		opcode_t opc;
		func_t fn;
		logic [6:0] fnCode;
		regspec_t rt;
		regspec_t ra;
		regspec_t rb;
		int idx;
		int i;
		curTest = "random";
		checkWrite(CsrIssued, 32'd0, RespOkay);
		for (i = 0; i < 50; i++)
		begin
			opc = opc.first();
			idx = int'(lfsrBits(5));
			repeat (idx)
				opc = opc.next();
			// Index 25 stands for an undefined function code
			idx = int'(lfsrBits(5)) % 26;
			fn = fn.first();
			repeat (idx % 25)
				fn = fn.next();
			if (idx == 25)
				fnCode = 7'h7F;
			else
				fnCode = fn;
			rt = regspec_t'(lfsrBits(6));
			ra = regspec_t'(lfsrBits(6));
			rb = regspec_t'(lfsrBits(6));
			issueAndRetire(makeInstr(opc, fnCode, rt, ra, rb));
		end
		checkRead(CsrIssued, 32'd50, RespOkay);
		checkWrite(CsrIssued, 32'd0, RespOkay);
		checkRead(CsrIssued, 32'd0, RespOkay);
	endtask

	task automatic testErrors();
		logic [31:0] data;
		logic [1:0] resp;
		curTest = "errors";
		axiRead(5'h14, data, resp);
		compareResp(curTest, RespSlvErr, resp);
		checkWrite(5'h14, 32'h1234_5678, RespSlvErr);
		// The pending mask is read-only
		checkWrite(CsrPendLo, 32'hFFFF_FFFF, RespOkay);
		checkRead(CsrPendLo, 32'd0, RespOkay);
	endtask

	initial
	begin
		reset = 1'b1;
		inValid = 1'b0;
		inInstr = '0;
		outReady = 1'b1;
		wbValid = 1'b0;
		wbReg = '0;
		awvalid = 1'b0;
		awaddr = '0;
		wvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		bready = 1'b0;
		arvalid = 1'b0;
		araddr = '0;
		rready = 1'b0;
		repeat (2)
			@(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		testReset();
		testDecode();
		testHazard();
		testBackPressure();
		testRandom();
		testErrors();
		$display("Result: PASSED");
		$finish;
	end

endmodule
